//--- all.f
hw/lpcPkg.sv
hw/lpcPredictor.sv
hw/minErrorCompare.sv
hw/predictorOrderSearch.sv
testbench/tbClock.sv
testbench/predictorOrderSearch_assertions.sv
testbench/predictorOrderSearchTb.sv

//--- run.sh
#!/bin/sh
# Builds the predictor order search testbench with Verilator and runs it.
# Exits with a failing status unless the pass message is printed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module predictorOrderSearchTb \
    -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VpredictorOrderSearchTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- testbench/predictorOrderSearchTb.sv
/*
  Testbench for the predictor order search.
  Each row of the block table may reload coefficients and then streams
  one block of samples. A reference model computes the expected best
  order per block, checked when oDone pulses. Inputs change 1 ns after
  the rising edge and outputs are read on the falling edge.
*/

`timescale 1ns/1ns

module predictorOrderSearchTb;

    localparam int KindConstant = 0;
    localparam int KindRamp     = 1;
    localparam int KindParabola = 2;
    localparam int KindRandom   = 3;

    localparam int SchemeExact  = 0;
    localparam int SchemeZero   = 1;
    localparam int SchemeRandom = 2;

    localparam int NumRows        = 10;
    localparam int WatchdogCycles = NumRows * (lpcPkg::BlockSize + lpcPkg::MaxOrder + 20);

    typedef struct packed {
        int kind;
        int amplitude;
        int scheme;
        bit reload;
        int loadOrder;   // 0 reloads every order.
        bit gaps;
    } blockRow;

    blockRow blockTable [NumRows] = '{
        '{KindConstant, 1000,  SchemeExact,  1'b1, 0, 1'b0},
        '{KindRamp,     40,    SchemeZero,   1'b1, 0, 1'b0},
        '{KindRamp,     40,    SchemeExact,  1'b1, 2, 1'b0},
        '{KindParabola, 7,     SchemeExact,  1'b1, 3, 1'b0},
        '{KindRandom,   20000, SchemeRandom, 1'b1, 0, 1'b0},
        '{KindRandom,   20000, SchemeRandom, 1'b0, 0, 1'b0},
        '{KindRandom,   3000,  SchemeRandom, 1'b0, 0, 1'b1},
        '{KindRamp,     100,   SchemeExact,  1'b1, 9, 1'b0},
        '{KindRamp,     100,   SchemeExact,  1'b0, 9, 1'b0},
        '{KindConstant, -500,  SchemeZero,   1'b1, 9, 1'b0}
    };

    logic                                   iClock;
    logic                                   rstN;
    logic                                   iLoad;
    logic        [lpcPkg::OrderWidth-1:0]   iOrder;
    logic signed [lpcPkg::CoeffWidth-1:0]   iCoeff;
    logic                                   iValid;
    logic signed [lpcPkg::SampleWidth-1:0]  iSample;
    logic        [lpcPkg::OrderWidth-1:0]   oBestOrder;
    logic                                   oDone;

    int     seed = 32'h1b52;
    int     errorCount = 0;
    int     doneCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    bit     earlyFlagged = 1'b0;
    int     expectQueue [$];
    int     modelCoeff [lpcPkg::MaxOrder][lpcPkg::MaxOrder];   // [order - 1][tap - 1].
    int     modelHistory [lpcPkg::MaxOrder];
    longint modelTotal [lpcPkg::MaxOrder];
    int     modelIndex = 0;

    tbClock clockGen (
        .iClock(iClock),
        .rstN  (rstN)
    );

    predictorOrderSearch DUT (
        .iClock    (iClock),
        .rstN      (rstN),
        .iLoad     (iLoad),
        .iOrder    (iOrder),
        .iCoeff    (iCoeff),
        .iValid    (iValid),
        .iSample   (iSample),
        .oBestOrder(oBestOrder),
        .oDone     (oDone)
    );

    bind predictorOrderSearch predictorOrderSearch_assertions checks (
        .iClock    (iClock),
        .rstN      (rstN),
        .iValid    (iValid),
        .oDone     (oDone),
        .oBestOrder(oBestOrder)
    );

    task automatic checkValue(input string name, input int actual, input int expected,
                              output bit ok);
        ok = (actual == expected);
        if (!ok) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            errorCount++;
        end
    endtask

    // Q10 taps that predict the waveform without error.
    function automatic int exactCoeff(input int kind, input int order, input int tap);
        int taps [3];
        int needed;
        case (kind)
            KindConstant: begin
                taps   = '{1024, 0, 0};
                needed = 1;
            end
            KindRamp: begin
                taps   = '{2048, -1024, 0};
                needed = 2;
            end
            KindParabola: begin
                taps   = '{3072, -3072, 1024};
                needed = 3;
            end
            default: begin
                taps   = '{0, 0, 0};
                needed = 1;
            end
        endcase
        if (order < needed || tap > 3) begin
            return 0;
        end
        return taps[tap - 1];
    endfunction

    task automatic loadCoefficients(input blockRow row);
        int first;
        int last;
        int value;
        first = (row.loadOrder == 0) ? 1 : row.loadOrder;
        last  = (row.loadOrder == 0) ? lpcPkg::MaxOrder : row.loadOrder;
        for (int k = first; k <= last; k++) begin
            for (int j = 1; j <= k; j++) begin
                if (row.scheme == SchemeRandom) begin
                    value = $random(seed) % 16384;
                end else if (row.scheme == SchemeZero) begin
                    value = 0;
                end else begin
                    value = exactCoeff(row.kind, k, j);
                end
                iValid = 1'b0;
                iLoad  = 1'b1;
                iOrder = lpcPkg::OrderWidth'(k);
                iCoeff = lpcPkg::CoeffWidth'(value);
                modelCoeff[k - 1][j - 1] = value;
                @(posedge iClock);
                #1;
            end
        end
        iLoad = 1'b0;
    endtask

    // Residuals of every order, warm-up gate, totals and the tie rule.
    task automatic modelSample(input int x);
        longint                                sum;
        logic signed [lpcPkg::SampleWidth-1:0] prediction;
        logic signed [lpcPkg::SampleWidth-1:0] residual;
        int                                    magnitude;
        int                                    best;
        for (int k = 1; k <= lpcPkg::MaxOrder; k++) begin
            sum = 0;
            for (int j = 1; j <= k; j++) begin
                sum += longint'(modelCoeff[k - 1][j - 1]) * longint'(modelHistory[j - 1]);
            end
            prediction = lpcPkg::SampleWidth'(sum >>> lpcPkg::QlpShift);
            residual   = lpcPkg::SampleWidth'(x) - prediction;
            magnitude  = (residual < 0) ? -int'(residual) : int'(residual);
            if (modelIndex >= lpcPkg::MaxOrder) begin
                modelTotal[k - 1] += longint'(magnitude);
            end
        end
        for (int j = lpcPkg::MaxOrder - 1; j > 0; j--) begin
            modelHistory[j] = modelHistory[j - 1];
        end
        modelHistory[0] = x;
        modelIndex++;
        if (modelIndex == lpcPkg::BlockSize) begin
            best = 0;
            for (int k = 1; k < lpcPkg::MaxOrder; k++) begin
                if (modelTotal[k] < modelTotal[best]) begin
                    best = k;
                end
            end
            expectQueue.push_back(best + 1);
            for (int k = 0; k < lpcPkg::MaxOrder; k++) begin
                modelTotal[k] = 0;
            end
            modelIndex = 0;
        end
    endtask

    task automatic nextSample(input blockRow row, input int n, output int x);
        case (row.kind)
            KindConstant: x = row.amplitude;
            KindRamp:     x = row.amplitude * n;
            KindParabola: x = row.amplitude * n * n;
            default:      x = $random(seed) % row.amplitude;
        endcase
    endtask

    task automatic streamBlock(input blockRow row);
        int x;
        for (int n = 0; n < lpcPkg::BlockSize; n++) begin
            if (row.gaps && (n % 16 == 8)) begin
                iValid = 1'b0;   // One idle cycle inside the block.
                @(posedge iClock);
                #1;
            end
            nextSample(row, n, x);
            iValid  = 1'b1;
            iSample = lpcPkg::SampleWidth'(x);
            modelSample(x);
            @(posedge iClock);
            #1;
        end
    endtask

    always @(negedge iClock) begin : resultMonitor
        int expected;
        bit ok;
        if (rstN) begin
            if (oDone) begin
                if (expectQueue.size() == 0) begin
                    $display("Error: oDone pulsed with no block waiting for a result");
                    errorCount++;
                end else begin
                    expected = expectQueue.pop_front();
                    checkValue("oBestOrder", int'(oBestOrder), expected, ok);
                    if (ok) begin
                        passCount++;
                    end else begin
                        failCount++;
                    end
                    $display("Block %0d: best order %0d, expected %0d, %s", doneCount,
                             oBestOrder, expected, ok ? "ok" : "mismatch");
                end
                doneCount++;
            end else if (doneCount == 0 && !earlyFlagged) begin
                checkValue("oBestOrder", int'(oBestOrder), 1, ok);
                earlyFlagged = !ok;
            end
        end
    end

    initial begin : watchdog
        wait (rstN === 1'b1);
        repeat (WatchdogCycles) @(posedge iClock);
        $display("Timeout: the blocks did not finish within %0d cycles", WatchdogCycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        bit ok;
        iLoad   = 1'b0;
        iOrder  = '0;
        iCoeff  = '0;
        iValid  = 1'b0;
        iSample = '0;
        for (int k = 0; k < lpcPkg::MaxOrder; k++) begin
            modelHistory[k] = 0;
            modelTotal[k]   = 0;
            for (int j = 0; j < lpcPkg::MaxOrder; j++) begin
                modelCoeff[k][j] = 0;
            end
        end
        wait (rstN === 1'b1);
        checkValue("oDone", int'(oDone), 0, ok);
        checkValue("oBestOrder", int'(oBestOrder), 1, ok);
        for (int r = 0; r < NumRows; r++) begin
            if (blockTable[r].reload) begin
                loadCoefficients(blockTable[r]);
            end
            streamBlock(blockTable[r]);
        end
        iValid = 1'b0;
        wait (doneCount == NumRows);
        repeat (8) @(posedge iClock);   // Catch any extra oDone.
        $display("Blocks %0d, passed %0d, failed %0d, errors %0d",
                 doneCount, passCount, failCount, errorCount);
        if (errorCount == 0 && doneCount == NumRows) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- testbench/predictorOrderSearch_assertions.sv
/*
  Concurrent checks on the result outputs of the order search.
  Bound into predictorOrderSearch from the testbench. It counts valid
  samples on its own to find the last sample of each block.
*/

`timescale 1ns/1ns

module predictorOrderSearch_assertions (
    input logic                           iClock,
    input logic                           rstN,
    input logic                           iValid,
    input logic                           oDone,
    input logic [lpcPkg::OrderWidth-1:0]  oBestOrder
);

    logic [lpcPkg::CountWidth-1:0] validCount;
    logic                          blockEnd;

    assign blockEnd = iValid && (validCount == lpcPkg::CountWidth'(lpcPkg::BlockSize - 1));

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            validCount <= '0;
        end else if (iValid) begin
            if (blockEnd) begin
                validCount <= '0;
            end else begin
                validCount <= validCount + 1'b1;
            end
        end
    end

    doneSingleCycle: assert property (@(posedge iClock) disable iff (!rstN)
        oDone |=> !oDone)
        else $error("oDone stayed high for more than one cycle");

    doneAfterBlock: assert property (@(posedge iClock) disable iff (!rstN)
        blockEnd |-> ##4 oDone)
        else $error("oDone missing four cycles after the last sample of a block");

    doneOnlyAfterBlock: assert property (@(posedge iClock) disable iff (!rstN)
        oDone |-> $past(blockEnd, 4))
        else $error("oDone high without a block ending four cycles before");

    orderInRange: assert property (@(posedge iClock) disable iff (!rstN)
        (oBestOrder >= lpcPkg::OrderWidth'(1)) &&
        (oBestOrder <= lpcPkg::OrderWidth'(lpcPkg::MaxOrder)))
        else $error("oBestOrder outside 1 to MaxOrder");

endmodule

//--- testbench/tbClock.sv
/*
  Clock and reset source for the testbench.
  Makes a 4 ns clock and holds the active-low reset for five rising
  edges, then releases it 1 ns after the last of them.
*/

`timescale 1ns/1ns

module tbClock #(
    parameter int HalfPeriod  = 2,
    parameter int ResetCycles = 5
) (
    output logic iClock,
    output logic rstN
);

    initial begin
        iClock = 1'b0;
        forever #HalfPeriod iClock = ~iClock;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge iClock);
        #1;
        rstN = 1'b1;   // Lines up with the input drive time.
    end

endmodule

//--- hw/predictorOrderSearch.sv
/*
  Predictor order search top level.
  Twelve LPC predictors of orders 1 to 12 run on the same sample stream.
  Absolute residuals of samples past the warm-up are summed per order
  over a block of BlockSize samples. The block's last residual starts the
  comparator, and oDone pulses with oBestOrder four cycles after the last
  sample is taken. Load coefficients only while no block is in flight.
*/

`timescale 1ns/1ns

module predictorOrderSearch (
    input  logic                                   iClock,
    input  logic                                   rstN,
    input  logic                                   iLoad,
    input  logic        [lpcPkg::OrderWidth-1:0]   iOrder,
    input  logic signed [lpcPkg::CoeffWidth-1:0]   iCoeff,
    input  logic                                   iValid,
    input  logic signed [lpcPkg::SampleWidth-1:0]  iSample,
    output logic        [lpcPkg::OrderWidth-1:0]   oBestOrder,
    output logic                                   oDone
);

    logic [lpcPkg::CountWidth-1:0]          sampleIndex;
    logic                                   sampleCounted;
    logic                                   sampleLast;

    // Flags delayed to line up with the residuals and the error stage.
    logic                                   gateD1;
    logic                                   lastD1;
    logic                                   lastD2;

    logic                                   loadStrobe    [lpcPkg::MaxOrder];
    logic signed [lpcPkg::SampleWidth-1:0]  residual      [lpcPkg::MaxOrder];
    logic                                   residualValid [lpcPkg::MaxOrder];
    logic        [lpcPkg::SampleWidth-1:0]  magnitude     [lpcPkg::MaxOrder];
    logic        [lpcPkg::SampleWidth-1:0]  absErr        [lpcPkg::MaxOrder];
    logic                                   errValid      [lpcPkg::MaxOrder];
    logic        [lpcPkg::ErrorWidth-1:0]   totals        [lpcPkg::MaxOrder];
    logic        [lpcPkg::ErrorWidth-1:0]   totalNext     [lpcPkg::MaxOrder];

    assign sampleCounted = sampleIndex >= lpcPkg::CountWidth'(lpcPkg::MaxOrder);
    assign sampleLast    = sampleIndex == lpcPkg::CountWidth'(lpcPkg::BlockSize - 1);

    // Sample index within the block.
    always_ff @(posedge iClock) begin
        if (!rstN) begin
            sampleIndex <= '0;
            gateD1      <= 1'b0;
            lastD1      <= 1'b0;
            lastD2      <= 1'b0;
        end else begin
            gateD1 <= sampleCounted;
            lastD1 <= iValid && sampleLast;
            lastD2 <= lastD1;
            if (iValid) begin
                if (sampleLast) begin
                    sampleIndex <= '0;
                end else begin
                    sampleIndex <= sampleIndex + 1'b1;
                end
            end
        end
    end

    for (genvar k = 0; k < lpcPkg::MaxOrder; k++) begin : genOrder

        assign loadStrobe[k] = iLoad && (iOrder == lpcPkg::OrderWidth'(k + 1));

        lpcPredictor #(
            .Order(k + 1)
        ) predictor (
            .iClock   (iClock),
            .rstN     (rstN),
            .iLoad    (loadStrobe[k]),
            .iCoeff   (iCoeff),
            .iValid   (iValid),
            .iSample  (iSample),
            .oResidual(residual[k]),
            .oValid   (residualValid[k])
        );

        // Most negative residual maps to its unsigned magnitude.
        assign magnitude[k] = residual[k][lpcPkg::SampleWidth-1] ?
                              lpcPkg::SampleWidth'(-residual[k]) :
                              lpcPkg::SampleWidth'(residual[k]);

        assign totalNext[k] = errValid[k] ?
                              totals[k] + lpcPkg::ErrorWidth'(absErr[k]) :
                              totals[k];

        always_ff @(posedge iClock) begin
            absErr[k] <= magnitude[k];
        end

        always_ff @(posedge iClock) begin
            if (!rstN) begin
                errValid[k] <= 1'b0;
                totals[k]   <= '0;
            end else begin
                errValid[k] <= residualValid[k] && gateD1;   // Warm-up samples are skipped.
                totals[k]   <= lastD2 ? '0 : totalNext[k];
            end
        end

    end

    // The bus carries the totals with the block's last error already added.
    minErrorCompare compare (
        .iClock    (iClock),
        .rstN      (rstN),
        .iStart    (lastD2),
        .iTotal    (totalNext),
        .oBestOrder(oBestOrder),
        .oDone     (oDone)
    );

endmodule

//--- hw/minErrorCompare.sv
/*
  Finds the order with the smallest absolute-error total.
  Stage one picks a winner in each group of four totals and stage two
  picks among the groups. Strict less-than in ascending index order lets
  the lower order win a tie. oBestOrder and oDone follow iStart by two
  cycles and oBestOrder holds until the next result.
*/

`timescale 1ns/1ns

module minErrorCompare (
    input  logic                                iClock,
    input  logic                                rstN,
    input  logic                                iStart,
    input  logic [lpcPkg::ErrorWidth-1:0]       iTotal [lpcPkg::MaxOrder],
    output logic [lpcPkg::OrderWidth-1:0]       oBestOrder,
    output logic                                oDone
);

    logic [lpcPkg::ErrorWidth-1:0] groupValueNext [lpcPkg::CompareGroups];
    logic [lpcPkg::OrderWidth-1:0] groupIndexNext [lpcPkg::CompareGroups];
    logic [lpcPkg::ErrorWidth-1:0] groupValue [lpcPkg::CompareGroups];
    logic [lpcPkg::OrderWidth-1:0] groupIndex [lpcPkg::CompareGroups];
    logic                          startD1;

    logic [lpcPkg::ErrorWidth-1:0] finalValue;
    logic [lpcPkg::OrderWidth-1:0] finalIndex;

    // Stage one search inside each group.
    always_comb begin
        for (int g = 0; g < lpcPkg::CompareGroups; g++) begin
            groupValueNext[g] = iTotal[g * lpcPkg::CompareGroup];
            groupIndexNext[g] = lpcPkg::OrderWidth'(g * lpcPkg::CompareGroup);
            for (int i = 1; i < lpcPkg::CompareGroup; i++) begin
                if (iTotal[g * lpcPkg::CompareGroup + i] < groupValueNext[g]) begin
                    groupValueNext[g] = iTotal[g * lpcPkg::CompareGroup + i];
                    groupIndexNext[g] = lpcPkg::OrderWidth'(g * lpcPkg::CompareGroup + i);
                end
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (iStart) begin
            groupValue <= groupValueNext;
            groupIndex <= groupIndexNext;
        end
    end

    // Stage two search across the group winners.
    always_comb begin
        finalValue = groupValue[0];
        finalIndex = groupIndex[0];
        for (int g = 1; g < lpcPkg::CompareGroups; g++) begin
            if (groupValue[g] < finalValue) begin
                finalValue = groupValue[g];
                finalIndex = groupIndex[g];
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            startD1    <= 1'b0;
            oDone      <= 1'b0;
            oBestOrder <= lpcPkg::OrderWidth'(1);   // Order 1 until the first block.
        end else begin
            startD1 <= iStart;
            oDone   <= startD1;
            if (startD1) begin
                oBestOrder <= finalIndex + 1'b1;   // Index 0 is order 1.
            end
        end
    end

endmodule

//--- hw/lpcPredictor.sv
/*
  Fixed-point LPC predictor with a compile-time number of taps.
  Coefficients are written one word per iLoad strobe, c1 first, and the
  write index wraps after Order words. Each valid sample produces a
  registered residual one cycle later: x[n] minus the shifted
  prediction, wrapped to the sample width.
*/

`timescale 1ns/1ns

module lpcPredictor #(
    parameter int Order = 1
) (
    input  logic                                   iClock,
    input  logic                                   rstN,
    input  logic                                   iLoad,
    input  logic signed [lpcPkg::CoeffWidth-1:0]   iCoeff,
    input  logic                                   iValid,
    input  logic signed [lpcPkg::SampleWidth-1:0]  iSample,
    output logic signed [lpcPkg::SampleWidth-1:0]  oResidual,
    output logic                                   oValid
);

    localparam int IndexWidth = (Order > 1) ? $clog2(Order) : 1;

    logic signed [lpcPkg::CoeffWidth-1:0]  coeff [Order];
    logic signed [lpcPkg::SampleWidth-1:0] history [Order];   // history[0] is x[n-1].
    logic        [IndexWidth-1:0]          loadIndex;

    logic signed [lpcPkg::AccWidth-1:0]    predictionSum;
    logic signed [lpcPkg::AccWidth-1:0]    shiftedSum;
    logic signed [lpcPkg::SampleWidth-1:0] prediction;
    logic signed [lpcPkg::SampleWidth-1:0] residualNext;

    // Coefficient store with its wrapping write index.
    always_ff @(posedge iClock) begin
        if (!rstN) begin
            loadIndex <= '0;
            for (int j = 0; j < Order; j++) begin
                coeff[j] <= '0;
            end
        end else if (iLoad) begin
            coeff[loadIndex] <= iCoeff;
            if (loadIndex == IndexWidth'(Order - 1)) begin
                loadIndex <= '0;
            end else begin
                loadIndex <= loadIndex + 1'b1;
            end
        end
    end

    // Sum of c_j * x[n-j] over all taps.
    always_comb begin
        logic signed [lpcPkg::AccWidth-1:0] product;
        predictionSum = '0;
        for (int j = 0; j < Order; j++) begin
            product       = coeff[j] * history[j];   // Sign-extended to AccWidth.
            predictionSum = predictionSum + product;
        end
    end

    assign shiftedSum   = predictionSum >>> lpcPkg::QlpShift;
    assign prediction   = shiftedSum[lpcPkg::SampleWidth-1:0];
    assign residualNext = iSample - prediction;   // Wraps to the sample width.

    // Sample history starts from zero after reset.
    always_ff @(posedge iClock) begin
        if (!rstN) begin
            for (int j = 0; j < Order; j++) begin
                history[j] <= '0;
            end
        end else if (iValid) begin
            history[0] <= iSample;
            for (int j = 1; j < Order; j++) begin
                history[j] <= history[j - 1];
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            oValid <= 1'b0;
        end else begin
            oValid <= iValid;
        end
    end

    always_ff @(posedge iClock) begin
        if (iValid) begin
            oResidual <= residualNext;
        end
    end

endmodule

//--- hw/lpcPkg.sv
/*
  Shared constants for the LPC predictor order search.
  Widths, block length, quantization shift and order limits are used by
  the predictors, the comparator, the top level and the testbench.
  Reference them with scoped names such as lpcPkg::SampleWidth.
*/

package lpcPkg;

    // Audio sample and residual width, two's complement.
    localparam int SampleWidth = 16;

    // Signed quantized coefficient width.
    localparam int CoeffWidth = 15;

    // Arithmetic right shift applied to the prediction sum.
    localparam int QlpShift = 10;

    // Number of predictors and also the warm-up length of a block.
    localparam int MaxOrder = 12;

    localparam int OrderWidth = 4;   // Holds order numbers 1 to MaxOrder.

    // Width of each absolute-error total.
    localparam int ErrorWidth = 28;

    // Valid samples per block.
    localparam int BlockSize = 64;

    localparam int CountWidth = 7;   // In-block sample index.

    // Internal width of the prediction sum.
    // 31-bit products over twelve taps need 35 bits.
    localparam int AccWidth = 36;

    // Comparator splits the totals into groups of this size.
    localparam int CompareGroup = 4;

    localparam int CompareGroups = MaxOrder / CompareGroup;

endpackage
